// ==== vlog.f ====
+incdir+rtl
rtl/chess_pkg.sv
rtl/move_fifo.sv
rtl/square_unit.sv
rtl/column_unit.sv
rtl/move_sequencer.sv
rtl/move_gen_top.sv
sim/tb_move_gen.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the move generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim_run.log

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_move_gen \
	-Mdir obj_dir -o tb_move_gen
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_move_gen > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q ">>> FAIL" "$log_file"; then
	echo "simulation reported failure"
	exit 1
fi

if ! grep -q ">>> PASS" "$log_file"; then
	echo "simulation ended without a result"
	exit 1
fi

exit 0

// ==== sim/tb_move_gen.sv ====
`timescale 1ns/10ps

module tb_move_gen
	import chess_pkg::*;
();

	// every start/collect/check cycle counts as one run
	localparam int num_runs       = 28;
	localparam int cycles_per_run = 2000;
	localparam int collect_limit  = 1500;

	// direction tables, orthogonal first and then diagonal
	localparam int line_df [8]   = '{0, 1, 0, -1, 1, 1, -1, -1};
	localparam int line_dr [8]   = '{1, 0, -1, 0, 1, -1, -1, 1};
	localparam int knight_df [8] = '{1, 2, 2, 1, -1, -2, -2, -1};
	localparam int knight_dr [8] = '{2, 1, -1, -2, -2, -1, 1, 2};

	logic   clk;
	logic   reset;
	logic   start;
	board_t board;
	logic   side;
	logic   move_valid;
	move_t  move;
	logic   done;

	int     seed = 32'h4e86afe4;
	board_t work_board;
	logic   work_side;
	move_t  got_q [$];
	move_t  model_q [$];
	int     got_total;
	int     got_pawn;
	int     got_double;
	int     got_capture;
	int     got_promote;
	int     value_errors;
	int     count_errors;
	int     missing_moves;
	int     extra_moves;
	int     other_errors;
	int     total_errors;

	move_gen_top i_move_gen_top (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.board      (board),
		.side       (side),
		.move_valid (move_valid),
		.move       (move),
		.done       (done)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic compare_move(input string name, input move_t got, input move_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("ERR %s: move got %h expected %h (from %h to %h)", name, got, exp,
				got.from_sq, got.to_sq);
		end
	endtask

	task automatic compare_count(input string name, input int got, input int exp);
		if (got != exp) begin
			count_errors++;
			$display("ERR %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			value_errors++;
			$display("ERR %s: got %h expected %h", name, got, exp);
		end
	endtask

	function automatic bit on_board(input int f, input int r);
		return (f >= 0) && (f < 8) && (r >= 0) && (r < 8);
	endfunction

	function automatic piece_t piece_at(input board_t b, input int f, input int r);
		return b[f * 8 + r];
	endfunction

	task automatic add_expected(input int ff, input int fr, input int tf, input int tr,
		input bit cap, input bit dbl, input bit pro);
		move_t m;
		m.flags.capture     = cap;
		m.flags.double_step = dbl;
		m.flags.promote     = pro;
		m.from_sq.file      = ff[2:0];
		m.from_sq.rank      = fr[2:0];
		m.to_sq.file        = tf[2:0];
		m.to_sq.rank        = tr[2:0];
		model_q.push_back(m);
	endtask

	// pseudo-legal moves of the piece on one square
	task automatic model_piece(input board_t b, input logic s, input int f, input int r);
		piece_t p;
		piece_t t;
		int     fwd;
		int     promo_rank;
		int     tf;
		int     tr;
		int     df;
		int     dr;
		int     first;
		int     last;
		bit     knight;
		bit     slide;
		p = piece_at(b, f, r);
		if (p.kind == kind_empty || p.color != s)
			return;
		if (p.kind == kind_pawn) begin
			fwd        = s ? -1 : 1;
			promo_rank = s ? 0 : 7;
			tr         = r + fwd;
			if (!on_board(f, tr))
				return;
			t = piece_at(b, f, tr);
			if (t.kind == kind_empty) begin
				add_expected(f, r, f, tr, 0, 0, tr == promo_rank);
				t = piece_at(b, f, tr + fwd);
				if (r == (s ? 6 : 1) && t.kind == kind_empty)
					add_expected(f, r, f, tr + fwd, 0, 1, 0);
			end
			for (int d = -1; d <= 1; d += 2) begin
				if (on_board(f + d, tr)) begin
					t = piece_at(b, f + d, tr);
					if (t.kind != kind_empty && t.color != s)
						add_expected(f, r, f + d, tr, 1, 0, tr == promo_rank);
				end
			end
			return;
		end
		knight = (p.kind == kind_knight);
		slide  = (p.kind == kind_bishop) || (p.kind == kind_rook) || (p.kind == kind_queen);
		first  = (p.kind == kind_bishop) ? 4 : 0;
		last   = (p.kind == kind_rook) ? 3 : 7;
		for (int d = first; d <= last; d++) begin
			df = knight ? knight_df[d] : line_df[d];
			dr = knight ? knight_dr[d] : line_dr[d];
			tf = f + df;
			tr = r + dr;
			while (on_board(tf, tr)) begin
				t = piece_at(b, tf, tr);
				if (t.kind != kind_empty && t.color == s)
					break;
				add_expected(f, r, tf, tr, t.kind != kind_empty, 0, 0);
				if (t.kind != kind_empty || !slide)
					break;
				tf += df;
				tr += dr;
			end
		end
	endtask

	task automatic model_moves(input board_t b, input logic s);
		model_q.delete();
		for (int f = 0; f < 8; f++)
			for (int r = 0; r < 8; r++)
				model_piece(b, s, f, r);
	endtask

	task automatic place_piece(input int f, input int r, input logic c, input piece_kind_t k);
		piece_t p;
		p.color = c;
		p.kind  = k;
		work_board[f * 8 + r] = p;
	endtask

	task automatic set_initial_position();
		piece_kind_t back;
		work_board = '0;
		for (int f = 0; f < 8; f++) begin
			case (f)
				0, 7:    back = kind_rook;
				1, 6:    back = kind_knight;
				2, 5:    back = kind_bishop;
				3:       back = kind_queen;
				default: back = kind_king;
			endcase
			place_piece(f, 0, 1'b0, back);
			place_piece(f, 1, 1'b0, kind_pawn);
			place_piece(f, 6, 1'b1, kind_pawn);
			place_piece(f, 7, 1'b1, back);
		end
	endtask

	task automatic make_random_board();
		int n;
		int sq;
		int k;
		int rnd;
		piece_t p;
		work_board = '0;
		n = 4 + ($unsigned($random(seed)) % 8);
		for (int i = 0; i < n; i++) begin
			sq  = $unsigned($random(seed)) % 64;
			k   = 1 + ($unsigned($random(seed)) % 6);
			rnd = $random(seed);
			p.color = rnd[0];
			p.kind  = piece_kind_t'(k[2:0]);
			work_board[sq] = p;
		end
		rnd = $random(seed);
		work_side = rnd[0];
	endtask

	task automatic start_run(input board_t b, input logic s);
		@(posedge clk);
		start <= 1'b1;
		board <= b;
		side  <= s;
		@(posedge clk);
		start <= 1'b0;
	endtask

	// gather output moves until done rises
	task automatic collect_moves();
		int cycles;
		got_q.delete();
		cycles = 0;
		forever begin
			@(negedge clk);
			if (move_valid)
				got_q.push_back(move);
			if (done)
				break;
			cycles++;
			if (cycles > collect_limit) begin
				other_errors++;
				$display("done did not rise within %0d cycles", collect_limit);
				break;
			end
		end
	endtask

	// multiset match of the collected moves against the model
	task automatic check_moves(input string name, input board_t b, input logic s);
		move_t  m;
		piece_t p;
		int     pos;
		model_moves(b, s);
		compare_count({name, " move count"}, got_q.size(), model_q.size());
		got_total   = got_q.size();
		got_pawn    = 0;
		got_double  = 0;
		got_capture = 0;
		got_promote = 0;
		foreach (got_q[i]) begin
			m = got_q[i];
			p = b[m.from_sq.file * 8 + m.from_sq.rank];
			got_pawn    += (p.kind == kind_pawn);
			got_double  += m.flags.double_step;
			got_capture += m.flags.capture;
			got_promote += m.flags.promote;
			pos = -1;
			for (int j = 0; j < model_q.size(); j++) begin
				if (model_q[j].from_sq == m.from_sq && model_q[j].to_sq == m.to_sq) begin
					pos = j;
					break;
				end
			end
			if (pos < 0) begin
				extra_moves++;
				$display("%s: unexpected move from square %h to square %h", name,
					m.from_sq, m.to_sq);
			end else begin
				compare_move(name, m, model_q[pos]);
				model_q.delete(pos);
			end
		end
		foreach (model_q[j]) begin
			missing_moves++;
			$display("%s: move from square %h to square %h never came out", name,
				model_q[j].from_sq, model_q[j].to_sq);
		end
	endtask

	task automatic run_board(input string name, input board_t b, input logic s);
		start_run(b, s);
		collect_moves();
		check_moves(name, b, s);
	endtask

	task automatic test_after_reset();
		repeat (3) begin
			@(negedge clk);
			compare_bit("move_valid after reset", move_valid, 1'b0);
			compare_bit("done after reset", done, 1'b0);
		end
	endtask

	task automatic test_initial_position();
		set_initial_position();
		run_board("initial white", work_board, 1'b0);
		compare_count("white total", got_total, 20);
		compare_count("white pawn moves", got_pawn, 16);
		compare_count("white double steps", got_double, 8);
		compare_count("white knight moves", got_total - got_pawn, 4);
		run_board("initial black", work_board, 1'b1);
		compare_count("black total", got_total, 20);
		compare_count("black double steps", got_double, 8);
	endtask

	task automatic test_queen_and_rook();
		work_board = '0;
		place_piece(3, 3, 1'b0, kind_queen);
		run_board("queen d4", work_board, 1'b0);
		compare_count("queen total", got_total, 27);
		compare_count("queen captures", got_capture, 0);
		// own pawn on a2 closes the file for the rook
		work_board = '0;
		place_piece(0, 0, 1'b0, kind_rook);
		place_piece(0, 1, 1'b0, kind_pawn);
		run_board("rook a1", work_board, 1'b0);
		compare_count("rook moves", got_total - got_pawn, 7);
		compare_count("pawn a2 moves", got_pawn, 2);
	endtask

	task automatic test_capture_stop();
		// bishop c1, enemy knight e3, enemy rook g5 hidden behind it
		work_board = '0;
		place_piece(2, 0, 1'b0, kind_bishop);
		place_piece(4, 2, 1'b1, kind_knight);
		place_piece(6, 4, 1'b1, kind_rook);
		run_board("bishop capture", work_board, 1'b0);
		compare_count("bishop total", got_total, 4);
		compare_count("bishop captures", got_capture, 1);
	endtask

	task automatic test_pawn_promotion();
		work_board = '0;
		place_piece(1, 6, 1'b0, kind_pawn);
		place_piece(0, 7, 1'b1, kind_rook);
		place_piece(2, 7, 1'b1, kind_rook);
		run_board("pawn b7", work_board, 1'b0);
		compare_count("promotion total", got_total, 3);
		compare_count("promotion flags", got_promote, 3);
		compare_count("promotion captures", got_capture, 2);
		// e2 blocked by e3, only the capture on d3 remains
		work_board = '0;
		place_piece(4, 1, 1'b0, kind_pawn);
		place_piece(4, 2, 1'b1, kind_pawn);
		place_piece(3, 2, 1'b1, kind_knight);
		run_board("blocked pawn", work_board, 1'b0);
		compare_count("blocked total", got_total, 1);
		compare_count("blocked captures", got_capture, 1);
		compare_count("blocked double steps", got_double, 0);
	endtask

	task automatic test_start_while_busy();
		board_t first_board;
		set_initial_position();
		first_board = work_board;
		// done holds from the previous run
		repeat (5) begin
			@(negedge clk);
			compare_bit("done held", done, 1'b1);
		end
		@(posedge clk);
		start <= 1'b1;
		board <= first_board;
		side  <= 1'b0;
		@(negedge clk);
		compare_bit("done before start sampled", done, 1'b1);
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		compare_bit("done after start", done, 1'b0);
		work_board = '0;
		place_piece(3, 3, 1'b1, kind_queen);
		fork
			collect_moves();
			begin
				repeat (4) @(posedge clk);
				start <= 1'b1;
				board <= work_board;
				side  <= 1'b1;
				@(posedge clk);
				start <= 1'b0;
			end
		join
		check_moves("start while busy", first_board, 1'b0);
		compare_count("busy run total", got_total, 20);
	endtask

	task automatic test_random_boards();
		for (int i = 0; i < 20; i++) begin
			make_random_board();
			run_board($sformatf("random board %0d", i), work_board, work_side);
		end
	endtask

	initial begin
		repeat (num_runs * cycles_per_run + 10) @(posedge clk);
		$display("watchdog: run did not end within %0d cycles", num_runs * cycles_per_run);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		reset         = 1'b1;
		start         = 1'b0;
		board         = '0;
		side          = 1'b0;
		work_board    = '0;
		work_side     = 1'b0;
		value_errors  = 0;
		count_errors  = 0;
		missing_moves = 0;
		extra_moves   = 0;
		other_errors  = 0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		test_after_reset();
		test_initial_position();
		test_queen_and_rook();
		test_capture_stop();
		test_pawn_promotion();
		test_start_while_busy();
		test_random_boards();
		total_errors = value_errors + count_errors + missing_moves + extra_moves + other_errors;
		$display("errors: value %0d, count %0d, missing %0d, extra %0d, other %0d",
			value_errors, count_errors, missing_moves, extra_moves, other_errors);
		if (total_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== rtl/move_gen_top.sv ====
`timescale 1ns/10ps

module move_gen_top
	import chess_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   start,
	input  board_t board,
	input  logic   side,
	output logic   move_valid,
	output move_t  move,
	output logic   done
);
	board_t      lat_board;
	logic        lat_side;
	logic        col_start;
	logic [7:0]  col_empty;
	logic [7:0]  col_done;
	logic [7:0]  col_rd;
	move_t [7:0] col_move;

	move_sequencer i_move_sequencer (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.board_in   (board),
		.side_in    (side),
		.board      (lat_board),
		.side       (lat_side),
		.col_start  (col_start),
		.col_empty  (col_empty),
		.col_done   (col_done),
		.col_rd     (col_rd),
		.col_move   (col_move),
		.move_valid (move_valid),
		.move       (move),
		.done       (done)
	);

	// one unit per file, a to h
	for (genvar f = 0; f < 8; f++) begin : g_col
		column_unit i_column_unit (
			.clk       (clk),
			.reset     (reset),
			.start     (col_start),
			.board     (lat_board),
			.side      (lat_side),
			.file      (3'(f)),
			.col_rd    (col_rd[f]),
			.col_move  (col_move[f]),
			.col_empty (col_empty[f]),
			.col_done  (col_done[f])
		);
	end

endmodule

// ==== rtl/move_sequencer.sv ====
`timescale 1ns/10ps

module move_sequencer
	import chess_pkg::*;
(
	input  logic            clk,
	input  logic            reset,
	input  logic            start,
	input  board_t          board_in,
	input  logic            side_in,
	output board_t          board,
	output logic            side,
	output logic            col_start,
	input  logic [7:0]      col_empty,
	input  logic [7:0]      col_done,
	output logic [7:0]      col_rd,
	input  move_t [7:0]     col_move,
	output logic            move_valid,
	output move_t           move,
	output logic            done
);
	logic       busy;
	logic       launch;
	logic       finish;
	logic       rd_any;
	logic [2:0] rd_idx;
	logic [2:0] out_idx;

	// fixed priority, lowest column first
	always_comb begin
		rd_any = 1'b0;
		rd_idx = 3'd0;
		for (int i = 7; i >= 0; i--) begin
			if (busy && !col_empty[i]) begin
				rd_any = 1'b1;
				rd_idx = 3'(i);
			end
		end
	end

	assign col_rd = rd_any ? (8'b1 << rd_idx) : 8'b0;
	assign launch = start && !busy;
	// col_done still shows the last run while col_start is high
	assign finish = busy && !col_start && (&col_done) && (&col_empty);
	assign move   = col_move[out_idx];

	always_ff @(posedge clk) begin
		if (reset) begin
			busy       <= 1'b0;
			col_start  <= 1'b0;
			move_valid <= 1'b0;
			done       <= 1'b0;
		end else begin
			col_start  <= launch;
			move_valid <= rd_any;
			if (launch) begin
				busy <= 1'b1;
				done <= 1'b0;
			end else if (finish) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (launch) begin
			board <= board_in;
			side  <= side_in;
		end
		if (rd_any)
			out_idx <= rd_idx;
	end

endmodule

// ==== rtl/column_unit.sv ====
`timescale 1ns/10ps

`include "chess_defs.svh"

module column_unit
	import chess_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       start,
	input  board_t     board,
	input  logic       side,
	input  logic [2:0] file,
	input  logic       col_rd,
	output move_t      col_move,
	output logic       col_empty,
	output logic       col_done
);
	typedef enum logic [1:0] {
		cu_wait = 2'b01,
		cu_getm = 2'b11,
		cu_done = 2'b10
	} state_t;

	state_t     state;
	logic [7:0] sq_wr;
	logic [7:0] sq_rd;
	logic [7:0] sq_empty;
	logic [7:0] finished;
	move_t      sq_wmove [8];
	move_t      sq_rdata [8];
	logic [2:0] row;
	logic [2:0] pick_row;
	logic       pick_ok;
	logic       rd_valid;
	logic       at_end;
	logic       col_wr;
	move_t      cur_move;

	for (genvar r = 0; r < 8; r++) begin : g_row
		square_t pos;

		assign pos = {file, 3'(r)};

		square_unit i_square_unit (
			.clk   (clk),
			.reset (reset),
			.start (start),
			.board (board),
			.side  (side),
			.pos   (pos),
			.wr    (sq_wr[r]),
			.wmove (sq_wmove[r])
		);

		move_fifo #(.DEPTH(`SQ_FIFO_DEPTH)) i_sq_fifo (
			.clk   (clk),
			.reset (reset),
			.wr    (sq_wr[r]),
			.wdata (sq_wmove[r]),
			.rd    (sq_rd[r]),
			.rdata (sq_rdata[r]),
			.empty (sq_empty[r])
		);
	end

	// highest unfinished row with something queued wins
	always_comb begin
		pick_ok  = 1'b0;
		pick_row = 3'd0;
		for (int i = 0; i < 8; i++) begin
			if (!sq_empty[i] && !finished[i]) begin
				pick_ok  = 1'b1;
				pick_row = 3'(i);
			end
		end
	end

	// read data shows up one cycle after the read enable
	assign cur_move = sq_rdata[row];
	assign at_end   = rd_valid && `IS_END_MARKER(cur_move);
	assign col_wr   = rd_valid && !at_end;
	assign sq_rd    = ((state == cu_getm) && !sq_empty[row] && !at_end) ? (8'b1 << row) : 8'b0;
	assign col_done = (state == cu_done);

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= cu_wait;
			finished <= 8'h00;
			row      <= 3'd0;
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= |sq_rd;
			case (state)
				cu_wait: begin
					if (&finished) begin
						state <= cu_done;
					end else if (pick_ok) begin
						state <= cu_getm;
						row   <= pick_row;
					end
				end
				cu_getm: begin
					if (at_end) begin
						finished[row] <= 1'b1;
						state         <= cu_wait;
					end
				end
				default: state <= cu_done;
			endcase
			// a new run clears the row flags
			if (start) begin
				state    <= cu_wait;
				finished <= 8'h00;
			end
		end
	end

	move_fifo #(.DEPTH(`COL_FIFO_DEPTH)) i_col_fifo (
		.clk   (clk),
		.reset (reset),
		.wr    (col_wr),
		.wdata (cur_move),
		.rd    (col_rd),
		.rdata (col_move),
		.empty (col_empty)
	);

endmodule

// ==== rtl/square_unit.sv ====
`timescale 1ns/10ps

`include "chess_defs.svh"

module square_unit
	import chess_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    start,
	input  board_t  board,
	input  logic    side,
	input  square_t pos,
	output logic    wr,
	output move_t   wmove
);
	typedef enum logic [1:0] {
		st_idle,
		st_walk,
		st_end
	} state_t;

	state_t      state;
	column_t     own_col;
	piece_t      own;
	piece_t      tgt;
	square_t     tgt_sq;
	move_flags_t flags;
	logic        own_turn;
	logic [2:0]  dir_idx;
	logic        first_step;
	logic [4:0]  cur_f;
	logic [4:0]  cur_r;
	logic [5:0]  first_delta;
	logic [5:0]  cur_delta;
	logic [5:0]  next_delta;
	logic        off_board;
	logic        tgt_empty;
	logic        tgt_enemy;
	logic        is_pawn;
	logic        is_slider;
	logic        on_start_rank;
	logic        last_dir;
	logic        emit;
	logic        cont;

	// deltas are {file, rank}, 3 bit two's complement each
	function automatic logic [5:0] ortho_delta(input logic [1:0] idx);
		case (idx)
			2'd0:    return {3'b000, 3'b001};
			2'd1:    return {3'b001, 3'b000};
			2'd2:    return {3'b000, 3'b111};
			default: return {3'b111, 3'b000};
		endcase
	endfunction

	function automatic logic [5:0] diag_delta(input logic [1:0] idx);
		case (idx)
			2'd0:    return {3'b001, 3'b001};
			2'd1:    return {3'b001, 3'b111};
			2'd2:    return {3'b111, 3'b111};
			default: return {3'b111, 3'b001};
		endcase
	endfunction

	function automatic logic [5:0] knight_delta(input logic [2:0] idx);
		case (idx)
			3'd0:    return {3'b001, 3'b010};
			3'd1:    return {3'b010, 3'b001};
			3'd2:    return {3'b010, 3'b111};
			3'd3:    return {3'b001, 3'b110};
			3'd4:    return {3'b111, 3'b110};
			3'd5:    return {3'b110, 3'b111};
			3'd6:    return {3'b110, 3'b001};
			default: return {3'b111, 3'b010};
		endcase
	endfunction

	// pawn order is forward, then the two capture diagonals
	function automatic logic [5:0] dir_delta(input piece_kind_t kind, input logic [2:0] idx,
		input logic black);
		logic [2:0] fwd;
		fwd = black ? 3'b111 : 3'b001;
		case (kind)
			kind_pawn: begin
				case (idx)
					3'd0:    return {3'b000, fwd};
					3'd1:    return {3'b111, fwd};
					default: return {3'b001, fwd};
				endcase
			end
			kind_knight: return knight_delta(idx);
			kind_bishop: return diag_delta(idx[1:0]);
			kind_rook:   return ortho_delta(idx[1:0]);
			default:     return idx[2] ? diag_delta(idx[1:0]) : ortho_delta(idx[1:0]);
		endcase
	endfunction

	function automatic logic [2:0] last_idx(input piece_kind_t kind);
		case (kind)
			kind_pawn:   return 3'd2;
			kind_bishop: return 3'd3;
			kind_rook:   return 3'd3;
			default:     return 3'd7;
		endcase
	endfunction

	// 5 bit coordinate so that stepping off the board is visible in bits 4:3
	function automatic logic [4:0] step(input logic [4:0] base, input logic [2:0] d);
		return base + {{2{d[2]}}, d};
	endfunction

	assign own_col  = board[{pos.file, 3'b000} +: 8];
	assign own      = own_col[pos.rank];
	assign own_turn = (own.kind != kind_empty) && (own.color == side);

	assign first_delta = dir_delta(own.kind, 3'd0, side);
	assign cur_delta   = dir_delta(own.kind, dir_idx, side);
	assign next_delta  = dir_delta(own.kind, dir_idx + 3'd1, side);

	assign off_board = (|cur_f[4:3]) || (|cur_r[4:3]);
	assign tgt_sq    = {cur_f[2:0], cur_r[2:0]};
	assign tgt       = board[tgt_sq];
	assign tgt_empty = (tgt.kind == kind_empty);
	assign tgt_enemy = !tgt_empty && (tgt.color != side);

	assign is_pawn   = (own.kind == kind_pawn);
	assign is_slider = (own.kind == kind_bishop) || (own.kind == kind_rook) ||
		(own.kind == kind_queen);
	assign on_start_rank = side ? (pos.rank == 3'd6) : (pos.rank == 3'd1);
	assign last_dir  = (dir_idx == last_idx(own.kind));

	assign flags.capture     = tgt_enemy;
	assign flags.double_step = is_pawn && (dir_idx == 3'd0) && !first_step;
	assign flags.promote     = is_pawn && (cur_r[2:0] == (side ? 3'd0 : 3'd7));

	// decide whether this candidate is a move and whether the ray goes on
	always_comb begin
		emit = 1'b0;
		cont = 1'b0;
		if (!off_board) begin
			if (is_pawn) begin
				if (dir_idx == 3'd0) begin
					emit = tgt_empty;
					cont = tgt_empty && first_step && on_start_rank;
				end else begin
					emit = tgt_enemy;
				end
			end else begin
				emit = tgt_empty || tgt_enemy;
				cont = is_slider && tgt_empty;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			wr    <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					wr <= 1'b0;
					if (start)
						state <= own_turn ? st_walk : st_end;
				end
				st_walk: begin
					wr <= emit;
					if (!cont && last_dir)
						state <= st_end;
				end
				default: begin
					wr    <= 1'b1;
					state <= st_idle;
				end
			endcase
		end
	end

	// ray position, direction index and the move word
	always_ff @(posedge clk) begin
		case (state)
			st_idle: begin
				dir_idx    <= 3'd0;
				first_step <= 1'b1;
				cur_f      <= step({2'b00, pos.file}, first_delta[5:3]);
				cur_r      <= step({2'b00, pos.rank}, first_delta[2:0]);
			end
			st_walk: begin
				wmove <= {flags, pos, tgt_sq};
				if (cont) begin
					first_step <= 1'b0;
					cur_f      <= step(cur_f, cur_delta[5:3]);
					cur_r      <= step(cur_r, cur_delta[2:0]);
				end else begin
					dir_idx    <= dir_idx + 3'd1;
					first_step <= 1'b1;
					cur_f      <= step({2'b00, pos.file}, next_delta[5:3]);
					cur_r      <= step({2'b00, pos.rank}, next_delta[2:0]);
				end
			end
			default: wmove <= `END_MARKER(pos);
		endcase
	end

endmodule

// ==== rtl/move_fifo.sv ====
`timescale 1ns/10ps

`include "chess_defs.svh"

module move_fifo
	import chess_pkg::*;
#(
	parameter int DEPTH = `SQ_FIFO_DEPTH
) (
	input  logic  clk,
	input  logic  reset,
	input  logic  wr,
	input  move_t wdata,
	input  logic  rd,
	output move_t rdata,
	output logic  empty
);
	localparam int AW = $clog2(DEPTH);

	move_t         mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          do_wr;
	logic          do_rd;

	// pointer increment with wrap for any depth
	function automatic logic [AW-1:0] bump(input logic [AW-1:0] p);
		return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign empty = (count == '0);
	assign do_wr = wr && (count != (AW + 1)'(DEPTH));
	assign do_rd = rd && !empty;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= bump(wr_ptr);
			if (do_rd)
				rd_ptr <= bump(rd_ptr);
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// storage and registered read port
	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wdata;
		if (do_rd)
			rdata <= mem[rd_ptr];
	end

endmodule

// ==== rtl/chess_pkg.sv ====
package chess_pkg;

	// piece kind, 3 bits, empty square is zero
	typedef enum logic [2:0] {
		kind_empty  = 3'd0,
		kind_pawn   = 3'd1,
		kind_knight = 3'd2,
		kind_bishop = 3'd3,
		kind_rook   = 3'd4,
		kind_queen  = 3'd5,
		kind_king   = 3'd6
	} piece_kind_t;

	// color 1 means black
	typedef struct packed {
		logic        color;
		piece_kind_t kind;
	} piece_t;

	typedef struct packed {
		logic [2:0] file;
		logic [2:0] rank;
	} square_t;

	typedef struct packed {
		logic capture;
		logic double_step;
		logic promote;
	} move_flags_t;

	typedef struct packed {
		move_flags_t flags;
		square_t     from_sq;
		square_t     to_sq;
	} move_t;

	// indexed by file * 8 + rank, i.e. {file, rank}
	typedef piece_t [63:0] board_t;

	// the eight squares of one file, rank 0 in the low nibble
	typedef piece_t [7:0] column_t;

endpackage

// ==== rtl/chess_defs.svh ====
`ifndef CHESS_DEFS_SVH
`define CHESS_DEFS_SVH

// per-square FIFO, sized for a queen's 27 moves plus the end marker
`define SQ_FIFO_DEPTH 32

// per-column FIFO, drained at one entry per cycle by the sequencer
`define COL_FIFO_DEPTH 32

// a move from a square to itself closes that square's move list
`define END_MARKER(sq) {3'b000, (sq), (sq)}

// true for the end marker written after a square's last move
`define IS_END_MARKER(m) ((m).from_sq == (m).to_sq)

`endif
